//--- hw/la_core_pkg.sv
`default_nettype none

package la_core_pkg;

    localparam int XLEN       = 32;
    localparam int INST_W     = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_ANDN,
        ALU_ORN,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // inst[31:20] of the 3R group and the shift-immediate group
    localparam logic [11:0] OPC_3R_MAJOR        = 12'h001;
    localparam logic [11:0] OPC_SHIFT_IMM_MAJOR = 12'h004;

    // inst[19:15] inside the 3R group
    localparam logic [4:0] F3R_ADD_W = 5'h00;
    localparam logic [4:0] F3R_SUB_W = 5'h02;
    localparam logic [4:0] F3R_SLT   = 5'h04;
    localparam logic [4:0] F3R_SLTU  = 5'h05;
    localparam logic [4:0] F3R_NOR   = 5'h08;
    localparam logic [4:0] F3R_AND   = 5'h09;
    localparam logic [4:0] F3R_OR    = 5'h0a;
    localparam logic [4:0] F3R_XOR   = 5'h0b;
    localparam logic [4:0] F3R_ORN   = 5'h0c;
    localparam logic [4:0] F3R_ANDN  = 5'h0d;
    localparam logic [4:0] F3R_SLL_W = 5'h0e;
    localparam logic [4:0] F3R_SRL_W = 5'h0f;
    localparam logic [4:0] F3R_SRA_W = 5'h10;

    // inst[19:15] inside the shift-immediate group
    localparam logic [4:0] FSI_SLLI_W = 5'h01;
    localparam logic [4:0] FSI_SRLI_W = 5'h09;
    localparam logic [4:0] FSI_SRAI_W = 5'h11;

    // inst[31:22] of the 2RI12 forms
    localparam logic [9:0] OPC_2RI12_SLTI  = 10'h008;
    localparam logic [9:0] OPC_2RI12_SLTUI = 10'h009;
    localparam logic [9:0] OPC_2RI12_ADDI  = 10'h00a;
    localparam logic [9:0] OPC_2RI12_ANDI  = 10'h00d;
    localparam logic [9:0] OPC_2RI12_ORI   = 10'h00e;
    localparam logic [9:0] OPC_2RI12_XORI  = 10'h00f;

    // inst[31:25] of lu12i.w
    localparam logic [6:0] OPC_LU12I = 7'h0a;

endpackage

`default_nettype wire

//--- hw/regfile.sv
`default_nettype none

module regfile
    import la_core_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr_a,
    output word_t     rdata_a,
    input  reg_addr_t raddr_b,
    output word_t     rdata_b,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // decode clears write enable for rd == 0, so r0 never gets a write
    a_no_r0_write: assert property (
        @(posedge clk) we |-> (waddr != '0)
    ) else $error("regfile: write requested to r0");

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`default_nettype none

module decode_stage
    import la_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      inst_valid,
    input  inst_t     inst,
    output logic      inst_allowin,
    input  logic      ex_allowin,
    output logic      ds_valid_out,
    output alu_op_e   ds_op,
    output word_t     ds_src_a,
    output word_t     ds_src_b,
    output reg_addr_t ds_dest,
    output logic      ds_we,
    output reg_addr_t rf_raddr_a,
    output reg_addr_t rf_raddr_b,
    input  word_t     rf_rdata_a,
    input  word_t     rf_rdata_b,
    input  logic      ex_fwd_valid,
    input  reg_addr_t ex_fwd_dest,
    input  word_t     ex_fwd_data,
    input  logic      wb_fwd_valid,
    input  reg_addr_t wb_fwd_dest,
    input  word_t     wb_fwd_data
);

    logic ds_valid;
    inst_t ds_inst;

    reg_addr_t rj;
    reg_addr_t rk;
    reg_addr_t rd;
    logic [11:0] major;
    logic [4:0] minor;
    logic [9:0] op_2ri12;
    logic [6:0] op_lu12i;

    logic [SHAMT_W-1:0] ui5;
    logic [11:0] i12;
    logic [19:0] si20;

    alu_op_e op;
    logic supported;
    logic src_b_is_imm;
    word_t imm;
    word_t rj_value;
    word_t rk_value;

    assign inst_allowin = ~ds_valid | ex_allowin;
    assign ds_valid_out = ds_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (inst_allowin) begin
            ds_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_allowin) begin
            ds_inst <= inst;
        end
    end

    assign rd       = ds_inst[4:0];
    assign rj       = ds_inst[9:5];
    assign rk       = ds_inst[14:10];
    assign major    = ds_inst[31:20];
    assign minor    = ds_inst[19:15];
    assign op_2ri12 = ds_inst[31:22];
    assign op_lu12i = ds_inst[31:25];

    assign ui5  = ds_inst[14:10];
    assign i12  = ds_inst[21:10];
    assign si20 = ds_inst[24:5];

    always_comb begin
        op           = ALU_ADD;
        supported    = 1'b1;
        src_b_is_imm = 1'b1;
        imm          = '0;
        if (major == OPC_3R_MAJOR) begin
            src_b_is_imm = 1'b0;
            case (minor)
                F3R_ADD_W: op = ALU_ADD;
                F3R_SUB_W: op = ALU_SUB;
                F3R_SLT:   op = ALU_SLT;
                F3R_SLTU:  op = ALU_SLTU;
                F3R_NOR:   op = ALU_NOR;
                F3R_AND:   op = ALU_AND;
                F3R_OR:    op = ALU_OR;
                F3R_XOR:   op = ALU_XOR;
                F3R_ORN:   op = ALU_ORN;
                F3R_ANDN:  op = ALU_ANDN;
                F3R_SLL_W: op = ALU_SLL;
                F3R_SRL_W: op = ALU_SRL;
                F3R_SRA_W: op = ALU_SRA;
                default:   supported = 1'b0;
            endcase
        end else if (major == OPC_SHIFT_IMM_MAJOR) begin
            imm = {{(XLEN-SHAMT_W){1'b0}}, ui5};
            case (minor)
                FSI_SLLI_W: op = ALU_SLL;
                FSI_SRLI_W: op = ALU_SRL;
                FSI_SRAI_W: op = ALU_SRA;
                default:    supported = 1'b0;
            endcase
        end else if (op_lu12i == OPC_LU12I) begin
            op  = ALU_LUI;
            imm = {si20, 12'b0};
        end else begin
            // si12 by default, logic ops override with ui12
            imm = {{(XLEN-12){i12[11]}}, i12};
            case (op_2ri12)
                OPC_2RI12_SLTI:  op = ALU_SLT;
                OPC_2RI12_SLTUI: op = ALU_SLTU;
                OPC_2RI12_ADDI:  op = ALU_ADD;
                OPC_2RI12_ANDI: begin
                    op  = ALU_AND;
                    imm = {{(XLEN-12){1'b0}}, i12};
                end
                OPC_2RI12_ORI: begin
                    op  = ALU_OR;
                    imm = {{(XLEN-12){1'b0}}, i12};
                end
                OPC_2RI12_XORI: begin
                    op  = ALU_XOR;
                    imm = {{(XLEN-12){1'b0}}, i12};
                end
                default: supported = 1'b0;
            endcase
        end
    end

    assign rf_raddr_a = rj;
    assign rf_raddr_b = rk;

    // execute holds the younger producer, so it wins over writeback
    assign rj_value = (rj != '0 && ex_fwd_valid && ex_fwd_dest == rj) ? ex_fwd_data :
                      (rj != '0 && wb_fwd_valid && wb_fwd_dest == rj) ? wb_fwd_data :
                      rf_rdata_a;
    assign rk_value = (rk != '0 && ex_fwd_valid && ex_fwd_dest == rk) ? ex_fwd_data :
                      (rk != '0 && wb_fwd_valid && wb_fwd_dest == rk) ? wb_fwd_data :
                      rf_rdata_b;

    // unsupported words run as 0 + 0 so they retire a zero result
    assign ds_op    = op;
    assign ds_src_a = supported ? rj_value : '0;
    assign ds_src_b = !supported ? '0 : (src_b_is_imm ? imm : rk_value);
    assign ds_dest  = rd;
    assign ds_we    = supported && (rd != '0);

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`default_nettype none

module execute_stage
    import la_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_valid,
    input  alu_op_e   ds_op,
    input  word_t     ds_src_a,
    input  word_t     ds_src_b,
    input  reg_addr_t ds_dest,
    input  logic      ds_we,
    output logic      ex_allowin,
    input  logic      wb_allowin,
    output logic      ex_valid,
    output reg_addr_t ex_dest,
    output logic      ex_we,
    output word_t     ex_result,
    output logic      ex_fwd_valid
);

    logic es_valid;
    alu_op_e op_r;
    word_t src_a_r;
    word_t src_b_r;
    reg_addr_t dest_r;
    logic we_r;
    logic [SHAMT_W-1:0] shamt;

    assign ex_allowin = ~es_valid | wb_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (ex_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && ex_allowin) begin
            op_r    <= ds_op;
            src_a_r <= ds_src_a;
            src_b_r <= ds_src_b;
            dest_r  <= ds_dest;
            we_r    <= ds_we;
        end
    end

    assign shamt = src_b_r[SHAMT_W-1:0];

    always_comb begin
        case (op_r)
            ALU_ADD:  ex_result = src_a_r + src_b_r;
            ALU_SUB:  ex_result = src_a_r - src_b_r;
            ALU_SLT:  ex_result = {{(XLEN-1){1'b0}}, $signed(src_a_r) < $signed(src_b_r)};
            ALU_SLTU: ex_result = {{(XLEN-1){1'b0}}, src_a_r < src_b_r};
            ALU_AND:  ex_result = src_a_r & src_b_r;
            ALU_OR:   ex_result = src_a_r | src_b_r;
            ALU_XOR:  ex_result = src_a_r ^ src_b_r;
            ALU_NOR:  ex_result = ~(src_a_r | src_b_r);
            ALU_ANDN: ex_result = src_a_r & ~src_b_r;
            ALU_ORN:  ex_result = src_a_r | ~src_b_r;
            ALU_SLL:  ex_result = src_a_r << shamt;
            ALU_SRL:  ex_result = src_a_r >> shamt;
            ALU_SRA:  ex_result = word_t'($signed(src_a_r) >>> shamt);
            // immediate already sits in the upper 20 bits
            ALU_LUI:  ex_result = src_b_r;
            default:  ex_result = '0;
        endcase
    end

    assign ex_valid     = es_valid;
    assign ex_dest      = dest_r;
    assign ex_we        = we_r;
    assign ex_fwd_valid = es_valid & we_r;

endmodule

`default_nettype wire

//--- hw/writeback_stage.sv
`default_nettype none

module writeback_stage
    import la_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  reg_addr_t ex_dest,
    input  logic      ex_we,
    input  word_t     ex_result,
    output logic      wb_allowin,
    output logic      result_valid,
    input  logic      result_ready,
    output reg_addr_t result_dest,
    output logic      result_we,
    output word_t     result_data,
    output logic      rf_we,
    output logic      wb_fwd_valid
);

    logic ws_valid;
    reg_addr_t dest_r;
    logic we_r;
    word_t data_r;

    assign wb_allowin = ~ws_valid | result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (wb_allowin) begin
            ws_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && wb_allowin) begin
            dest_r <= ex_dest;
            we_r   <= ex_we;
            data_r <= ex_result;
        end
    end

    assign result_valid = ws_valid;
    assign result_dest  = dest_r;
    assign result_we    = we_r;
    assign result_data  = data_r;

    // register file is written on the retire edge only
    assign rf_we        = ws_valid & result_ready & we_r;
    assign wb_fwd_valid = ws_valid & we_r;

    a_stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result_dest)
            && $stable(result_we) && $stable(result_data)
    ) else $error("writeback: result changed while stalled");

endmodule

`default_nettype wire

//--- hw/la_int_core.sv
`default_nettype none

module la_int_core
    import la_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      inst_valid,
    input  inst_t     inst,
    output logic      inst_allowin,
    output logic      result_valid,
    input  logic      result_ready,
    output reg_addr_t result_dest,
    output logic      result_we,
    output word_t     result_data
);

    logic ex_allowin;
    logic wb_allowin;

    // decode to execute
    logic ds_valid;
    alu_op_e ds_op;
    word_t ds_src_a;
    word_t ds_src_b;
    reg_addr_t ds_dest;
    logic ds_we;

    // execute to writeback, also forwarded back to decode
    logic ex_valid;
    reg_addr_t ex_dest;
    logic ex_we;
    word_t ex_result;
    logic ex_fwd_valid;

    logic wb_fwd_valid;
    logic rf_we;

    reg_addr_t rf_raddr_a;
    reg_addr_t rf_raddr_b;
    word_t rf_rdata_a;
    word_t rf_rdata_b;

    decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_allowin (inst_allowin),
        .ex_allowin   (ex_allowin),
        .ds_valid_out (ds_valid),
        .ds_op        (ds_op),
        .ds_src_a     (ds_src_a),
        .ds_src_b     (ds_src_b),
        .ds_dest      (ds_dest),
        .ds_we        (ds_we),
        .rf_raddr_a   (rf_raddr_a),
        .rf_raddr_b   (rf_raddr_b),
        .rf_rdata_a   (rf_rdata_a),
        .rf_rdata_b   (rf_rdata_b),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_dest  (ex_dest),
        .ex_fwd_data  (ex_result),
        .wb_fwd_valid (wb_fwd_valid),
        .wb_fwd_dest  (result_dest),
        .wb_fwd_data  (result_data)
    );

    execute_stage u_execute (
        .clk          (clk),
        .reset        (reset),
        .ds_valid     (ds_valid),
        .ds_op        (ds_op),
        .ds_src_a     (ds_src_a),
        .ds_src_b     (ds_src_b),
        .ds_dest      (ds_dest),
        .ds_we        (ds_we),
        .ex_allowin   (ex_allowin),
        .wb_allowin   (wb_allowin),
        .ex_valid     (ex_valid),
        .ex_dest      (ex_dest),
        .ex_we        (ex_we),
        .ex_result    (ex_result),
        .ex_fwd_valid (ex_fwd_valid)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_dest      (ex_dest),
        .ex_we        (ex_we),
        .ex_result    (ex_result),
        .wb_allowin   (wb_allowin),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_dest  (result_dest),
        .result_we    (result_we),
        .result_data  (result_data),
        .rf_we        (rf_we),
        .wb_fwd_valid (wb_fwd_valid)
    );

    regfile u_regfile (
        .clk     (clk),
        .raddr_a (rf_raddr_a),
        .rdata_a (rf_rdata_a),
        .raddr_b (rf_raddr_b),
        .rdata_b (rf_rdata_b),
        .we      (rf_we),
        .waddr   (result_dest),
        .wdata   (result_data)
    );

endmodule

`default_nettype wire

//--- include/la_inst_enc.svh
`ifndef LA_INST_ENC_SVH
`define LA_INST_ENC_SVH

// 3R group, minor is one of the F3R_* codes
function automatic la_core_pkg::inst_t enc_3r(
    input logic [4:0] minor,
    input la_core_pkg::reg_addr_t rd,
    input la_core_pkg::reg_addr_t rj,
    input la_core_pkg::reg_addr_t rk
);
    return {la_core_pkg::OPC_3R_MAJOR, minor, rk, rj, rd};
endfunction

// slli.w, srli.w, srai.w
function automatic la_core_pkg::inst_t enc_shift_imm(
    input logic [4:0] minor,
    input la_core_pkg::reg_addr_t rd,
    input la_core_pkg::reg_addr_t rj,
    input logic [la_core_pkg::SHAMT_W-1:0] ui5
);
    return {la_core_pkg::OPC_SHIFT_IMM_MAJOR, minor, ui5, rj, rd};
endfunction

// slti, sltui, addi.w, andi, ori, xori
function automatic la_core_pkg::inst_t enc_2ri12(
    input logic [9:0] opc,
    input la_core_pkg::reg_addr_t rd,
    input la_core_pkg::reg_addr_t rj,
    input logic [11:0] i12
);
    return {opc, i12, rj, rd};
endfunction

function automatic la_core_pkg::inst_t enc_lu12i(
    input la_core_pkg::reg_addr_t rd,
    input logic [19:0] si20
);
    return {la_core_pkg::OPC_LU12I, si20, rd};
endfunction

`endif

//--- verif/tb_la_int_core.sv
`default_nettype none

module tb_la_int_core
    import la_core_pkg::*;
();

    `include "la_inst_enc.svh"

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_INSTS      = 400;
    localparam int PREAMBLE       = 14;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 8 + 200;

    localparam alu_op_e OPS_3R [13] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR,
        ALU_AND, ALU_OR, ALU_XOR, ALU_ORN, ALU_ANDN, ALU_SLL, ALU_SRL, ALU_SRA};
    localparam logic [4:0] MINOR_3R [13] = '{F3R_ADD_W, F3R_SUB_W, F3R_SLT, F3R_SLTU,
        F3R_NOR, F3R_AND, F3R_OR, F3R_XOR, F3R_ORN, F3R_ANDN, F3R_SLL_W, F3R_SRL_W,
        F3R_SRA_W};
    localparam alu_op_e OPS_SHIFT [3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
    localparam logic [4:0] MINOR_SHIFT [3] = '{FSI_SLLI_W, FSI_SRLI_W, FSI_SRAI_W};
    // first three sign-extend and the last three zero-extend
    localparam alu_op_e OPS_2RI12 [6] = '{ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR,
        ALU_XOR};
    localparam logic [9:0] OPC_2RI12 [6] = '{OPC_2RI12_SLTI, OPC_2RI12_SLTUI,
        OPC_2RI12_ADDI, OPC_2RI12_ANDI, OPC_2RI12_ORI, OPC_2RI12_XORI};

    typedef struct packed {
        int        index;
        reg_addr_t dest;
        logic      we;
        word_t     data;
    } expect_t;

    logic      clk;
    logic      reset;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_allowin;
    logic      result_valid;
    logic      result_ready;
    reg_addr_t result_dest;
    logic      result_we;
    word_t     result_data;

    logic [31:0] lfsr_state;
    word_t       model_regs [NUM_REGS];
    expect_t     exp_q [$];
    int          mismatch_count;
    int          other_count;
    int          issued;
    int          retired;
    int          cycle_count;

    // instruction waiting to be accepted
    inst_t     cur_inst;
    alu_op_e   cur_op;
    reg_addr_t cur_rd;
    reg_addr_t cur_rj;
    reg_addr_t cur_rk;
    word_t     cur_imm;
    bit        cur_use_imm;
    bit        cur_supported;

    la_int_core u_dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_allowin (inst_allowin),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_dest  (result_dest),
        .result_we    (result_we),
        .result_data  (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    // reference ALU from the LA32R semantics
    function automatic word_t model_result(input alu_op_e op, input word_t a, input word_t b);
        word_t r;
        int sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 32'd1;
            ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_NOR:  r = ~(a | b);
            ALU_ANDN: r = a & ~b;
            ALU_ORN:  r = a | ~b;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA: begin
                r = a >> sh;
                if (a[31]) begin
                    r = r | ~(32'hffff_ffff >> sh);
                end
            end
            ALU_LUI:  r = b;
            default:  r = '0;
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t expected,
                                  input reg_addr_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: expected r%0d, actual r%0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic pick_instruction(input int idx);
        int kind;
        logic [31:0] draw;
        cur_rd        = reg_addr_t'(rand_bits(3));
        cur_rj        = reg_addr_t'(rand_bits(3));
        cur_rk        = reg_addr_t'(rand_bits(3));
        cur_supported = 1'b1;
        cur_use_imm   = 1'b1;
        cur_imm       = '0;
        cur_op        = ALU_ADD;
        if (idx < PREAMBLE) begin
            // r1..r7 start undefined in the DUT and get lu12i.w then ori
            cur_rd = reg_addr_t'(idx / 2 + 1);
            cur_rj = cur_rd;
            draw   = rand_bits(20);
            if (idx % 2 == 0) begin
                cur_op   = ALU_LUI;
                cur_imm  = {draw[19:0], 12'h000};
                cur_inst = enc_lu12i(cur_rd, draw[19:0]);
            end else begin
                cur_op   = ALU_OR;
                cur_imm  = {20'h0, draw[11:0]};
                cur_inst = enc_2ri12(OPC_2RI12_ORI, cur_rd, cur_rj, draw[11:0]);
            end
        end else if (rand_bits(4) == 0) begin
            // top six bits all ones match no kept group
            draw          = rand_bits(26);
            cur_inst      = {6'h3f, draw[25:0]};
            cur_rd        = cur_inst[4:0];
            cur_supported = 1'b0;
        end else begin
            kind = rand_bits(5) % 23;
            draw = rand_bits(20);
            if (kind < 13) begin
                cur_op      = OPS_3R[kind];
                cur_use_imm = 1'b0;
                cur_inst    = enc_3r(MINOR_3R[kind], cur_rd, cur_rj, cur_rk);
            end else if (kind < 16) begin
                cur_op   = OPS_SHIFT[kind - 13];
                cur_imm  = {27'h0, draw[4:0]};
                cur_inst = enc_shift_imm(MINOR_SHIFT[kind - 13], cur_rd, cur_rj, draw[4:0]);
            end else if (kind < 22) begin
                cur_op   = OPS_2RI12[kind - 16];
                cur_imm  = (kind - 16 >= 3) ? {20'h0, draw[11:0]}
                                            : {{20{draw[11]}}, draw[11:0]};
                cur_inst = enc_2ri12(OPC_2RI12[kind - 16], cur_rd, cur_rj, draw[11:0]);
            end else begin
                cur_op   = ALU_LUI;
                cur_imm  = {draw[19:0], 12'h000};
                cur_inst = enc_lu12i(cur_rd, draw[19:0]);
            end
        end
    endtask

    task automatic accept_instruction();
        expect_t e;
        word_t a;
        word_t b;
        a       = model_regs[cur_rj];
        b       = cur_use_imm ? cur_imm : model_regs[cur_rk];
        e.index = issued;
        e.dest  = cur_rd;
        e.we    = cur_supported && (cur_rd != 0);
        e.data  = cur_supported ? model_result(cur_op, a, b) : '0;
        if (e.we) begin
            model_regs[cur_rd] = e.data;
        end
        exp_q.push_back(e);
    endtask

    task automatic check_retire();
        expect_t e;
        if (exp_q.size() == 0) begin
            other_count++;
            $display("Error: a result retired with no instruction outstanding");
        end else begin
            e = exp_q.pop_front();
            check_reg_addr($sformatf("inst %0d dest", e.index), e.dest, result_dest);
            check_flag($sformatf("inst %0d we", e.index), e.we, result_we);
            check_word($sformatf("inst %0d data", e.index), e.data, result_data);
            retired++;
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
    endtask

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        other_count++;
        $display("Error: timeout after %0d cycles, %0d of %0d results retired",
                 cycle_count, retired, NUM_INSTS);
        report_counts();
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        bit have_inst;
        bit keep_valid;
        bit hold_pending;
        reg_addr_t hold_dest;
        logic hold_we;
        word_t hold_data;
        lfsr_state     = 32'ha8d9;
        mismatch_count = 0;
        other_count    = 0;
        issued         = 0;
        retired        = 0;
        have_inst      = 1'b0;
        keep_valid     = 1'b0;
        hold_pending   = 1'b0;
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst           = '0;
        result_ready   = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(CLK_PERIOD / 4);
        check_flag("reset result_valid", 1'b0, result_valid);
        check_flag("reset inst_allowin", 1'b1, inst_allowin);

        while (retired < NUM_INSTS) begin
            @(negedge clk);
            if (!have_inst && issued < NUM_INSTS) begin
                pick_instruction(issued);
                have_inst = 1'b1;
            end
            // an offered instruction stays on the port until accepted
            inst_valid   = keep_valid ? 1'b1 : (have_inst && rand_bits(2) != 0);
            inst         = cur_inst;
            result_ready = (rand_bits(2) != 0);
            #(CLK_PERIOD / 4);

            if (hold_pending) begin
                check_flag($sformatf("hold %0d valid", retired), 1'b1, result_valid);
                check_reg_addr($sformatf("hold %0d dest", retired), hold_dest, result_dest);
                check_flag($sformatf("hold %0d we", retired), hold_we, result_we);
                check_word($sformatf("hold %0d data", retired), hold_data, result_data);
            end
            if (result_valid && result_ready) begin
                check_retire();
            end
            if (inst_valid && inst_allowin) begin
                accept_instruction();
                issued++;
                have_inst  = 1'b0;
                keep_valid = 1'b0;
            end else begin
                keep_valid = inst_valid;
            end
            hold_pending = result_valid && !result_ready;
            hold_dest    = result_dest;
            hold_we      = result_we;
            hold_data    = result_data;
        end

        // pipeline must be empty once every instruction retired
        @(negedge clk);
        inst_valid   = 1'b0;
        result_ready = 1'b1;
        repeat (4) @(negedge clk);
        #(CLK_PERIOD / 4);
        check_flag("drain result_valid", 1'b0, result_valid);

        report_counts();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hw/la_core_pkg.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/la_int_core.sv
verif/tb_la_int_core.sv

//--- Bender.yml
package:
  name: la_int_core

sources:
  - files:
      - hw/la_core_pkg.sv
      - hw/regfile.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/writeback_stage.sv
      - hw/la_int_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_la_int_core.sv
